//--- build.f
kernel_pkg.sv
apb_cfg_regs.sv
ker_gearbox.sv
kernel_mem.sv
kernel_out.sv
kernel_top.sv
tb_kernel.sv

//--- tb_kernel.sv
`timescale 1ns/10ps
`default_nettype none

module tb_kernel;
    import kernel_pkg::*;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;
    localparam int MEM_WORDS    = 16;
    localparam int PIPE_ITEMS   = 3; // memory output register plus two slice entries.
    localparam int BEATS_2      = 32;
    localparam int BEATS_5      = 16;
    localparam int ITEMS_3      = 40;
    localparam int ITEMS_4      = 20;
    localparam int ITEMS_5      = 12;
    localparam int TIMEOUT_CYCLES =
        4 * (BEATS_2 + BEATS_5 + ITEMS_3 + ITEMS_4 + ITEMS_5) + RESET_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    cfg_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    str_word_t   str_data;
    logic        str_val;
    logic        str_rdy;
    ker_out_t    ker_out;
    logic        ker_val;
    logic        ker_rdy;

    logic [31:0] rand_state;
    ker_word_t   model [MEM_WORDS]; // words as the gearbox should pack them.
    int          check_cnt;
    int          err_cnt;
    int          base_checks;
    int          base_errs;
    int          cycles;

    // read window the monitor expects.
    mem_addr_t   win_start;
    mem_addr_t   win_end;
    int          item_goal;
    int          item_n;
    int          skip_left;
    logic        armed;
    logic        mon_done;

    kernel_top #(.MEM_WORDS(MEM_WORDS)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .str_data(str_data), .str_val(str_val), .str_rdy(str_rdy),
        .ker_out(ker_out), .ker_val(ker_val), .ker_rdy(ker_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // bias is the window's first word, kernels cycle over the rest.
    function automatic ker_out_t expected_item(input mem_addr_t s, input mem_addr_t e,
                                               input int n);
        ker_out_t item;
        int       k;
        k = int'(s) + 1 + (n % (int'(e) - int'(s)));
        item.bias   = model[s];
        item.kernel = model[k];
        return item;
    endfunction

    task automatic check_item(input ker_out_t got, input ker_out_t exp, input int n);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR ker_out item %0d got %h expected %h", n, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apb_access(input logic write, input cfg_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        logic rdy;
        @(negedge clk);
        psel    = 1'b1; // setup phase.
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata; // no wait states, access ends on this edge.
        err   = pslverr;
        rdy   = pready;
        check_bit("pready", rdy, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic start_write(input mem_addr_t e);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, CFG_KER_WR, {28'h0, e}, rdata, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic start_read(input mem_addr_t s, input mem_addr_t e);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, CFG_KER_RD, {12'h0, e, 12'h0, s}, rdata, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic wait_write_done(output logic [31:0] status);
        logic err;
        status = '0;
        while (!status[0]) begin
            apb_access(1'b0, CFG_STATUS, '0, status, err);
        end
    endtask

    // str_rdy comes from registers only, so the negedge value decides the next edge.
    task automatic stream_beats(input int n, input logic gaps);
        int        i;
        logic      held;
        str_word_t beat;
        i    = 0;
        held = 1'b0;
        beat = '0;
        while (i < n) begin
            @(negedge clk);
            if (!held && gaps && ((next_rand() >> 16) % 3 == 0)) begin
                str_val = 1'b0; // idle gap.
            end else begin
                if (!held) begin
                    beat = next_rand();
                    model[i / GBOX_RATIO][(i % GBOX_RATIO) * STR_WIDTH +: STR_WIDTH] = beat;
                end
                str_val  = 1'b1;
                str_data = beat;
                held     = !str_rdy;
                if (str_rdy) begin
                    i++;
                end
            end
        end
        @(negedge clk);
        str_val = 1'b0;
    endtask

    task automatic arm_window(input mem_addr_t s, input mem_addr_t e, input int goal,
                              input int skip);
        win_start = s;
        win_end   = e;
        item_goal = goal;
        item_n    = 0;
        skip_left = skip; // older items still in flight.
        mon_done  = 1'b0;
        armed     = 1'b1;
    endtask

    task automatic consume_items(input logic stalls);
        do begin
            @(negedge clk);
            if (mon_done) begin
                ker_rdy = 1'b0;
            end else if (stalls) begin
                ker_rdy = ((next_rand() >> 16) % 4 != 0);
            end else begin
                ker_rdy = 1'b1;
            end
        end while (!mon_done);
    endtask

    // with ker_rdy low the output path fills up and stops.
    task automatic let_output_settle();
        ker_rdy = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 check_cnt - base_checks, err_cnt - base_errs);
        base_checks = check_cnt;
        base_errs   = err_cnt;
    endtask

    always @(posedge clk) begin
        if (rst_n && ker_val && ker_rdy) begin
            if (skip_left > 0) begin
                skip_left--;
            end else if (armed) begin
                check_item(ker_out, expected_item(win_start, win_end, item_n), item_n);
                item_n++;
                if (item_n == item_goal) begin
                    armed    = 1'b0;
                    mon_done = 1'b1;
                end
            end else begin
                err_cnt++;
                $display("output item arrived while no read window was expected");
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        rand_state  = 32'hd19e;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        str_data    = '0;
        str_val     = 1'b0;
        ker_rdy     = 1'b0;
        check_cnt   = 0;
        err_cnt     = 0;
        base_checks = 0;
        base_errs   = 0;
        armed       = 1'b0;
        mon_done    = 1'b0;
        skip_left   = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_bit("ker_val", ker_val, 1'b0);
        check_bit("str_rdy", str_rdy, 1'b1);
        apb_access(1'b0, CFG_STATUS, '0, rdata, err);
        check_data("prdata", rdata, 32'h0);
        check_bit("pslverr", err, 1'b0);
        apb_access(1'b0, 8'h0c, '0, rdata, err); // unmapped.
        check_bit("pslverr", err, 1'b1);
        apb_access(1'b1, CFG_STATUS, 32'h3, rdata, err);
        check_bit("pslverr", err, 1'b1);
        finish_test(1, "reset state and APB errors");

        ker_rdy = 1'b1; // any item during the write is unexpected.
        start_write(4'd15);
        stream_beats(BEATS_2, 1'b0);
        wait_write_done(rdata);
        check_data("prdata", rdata, 32'h1);
        check_bit("str_rdy", str_rdy, 1'b1); // gearbox drained.
        finish_test(2, "full write window");

        arm_window(4'd0, 4'd15, ITEMS_3, 0);
        start_read(4'd0, 4'd15);
        consume_items(1'b0);
        finish_test(3, "full read window with wrap");

        let_output_settle();
        arm_window(4'd3, 4'd6, ITEMS_4, PIPE_ITEMS);
        start_read(4'd3, 4'd6);
        consume_items(1'b1);
        finish_test(4, "short window under back-pressure");

        let_output_settle();
        start_write(4'd7);
        stream_beats(BEATS_5, 1'b1);
        wait_write_done(rdata);
        check_data("prdata", rdata, 32'h3);
        arm_window(4'd2, 4'd7, ITEMS_5, PIPE_ITEMS);
        start_read(4'd2, 4'd7);
        consume_items(1'b0);
        finish_test(5, "rewrite with stream gaps");

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- kernel_top.sv
`timescale 1ns/10ps
`default_nettype none

module kernel_top #(
    parameter int MEM_WORDS = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire kernel_pkg::cfg_addr_t paddr,
    input  wire logic [31:0]           pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  wire kernel_pkg::str_word_t str_data,
    input  wire logic                  str_val,
    output logic                       str_rdy,
    output kernel_pkg::ker_out_t       ker_out,
    output logic                       ker_val,
    input  wire logic                  ker_rdy
);
    import kernel_pkg::*;

    wr_cfg_t   wr_cfg;
    rd_cfg_t   rd_cfg;
    logic      wr_done;
    logic      rd_active;
    ker_word_t wr_data;
    logic      wr_val;
    logic      wr_rdy;
    ker_out_t  mem_item;
    logic      mem_val;
    logic      mem_rdy;

    apb_cfg_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .wr_done(wr_done), .rd_active(rd_active),
        .wr_cfg(wr_cfg), .rd_cfg(rd_cfg)
    );

    ker_gearbox u_gbox (
        .clk(clk), .rst_n(rst_n),
        .str_data(str_data), .str_val(str_val), .str_rdy(str_rdy),
        .wr_data(wr_data), .wr_val(wr_val), .wr_rdy(wr_rdy)
    );

    kernel_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk(clk), .rst_n(rst_n),
        .wr_cfg(wr_cfg), .rd_cfg(rd_cfg),
        .wr_data(wr_data), .wr_val(wr_val), .wr_rdy(wr_rdy),
        .wr_done(wr_done), .rd_active(rd_active),
        .mem_item(mem_item), .mem_val(mem_val), .mem_rdy(mem_rdy)
    );

    kernel_out u_out (
        .clk(clk), .rst_n(rst_n),
        .mem_item(mem_item), .mem_val(mem_val), .mem_rdy(mem_rdy),
        .ker_out(ker_out), .ker_val(ker_val), .ker_rdy(ker_rdy)
    );

endmodule

`default_nettype wire

//--- kernel_out.sv
`timescale 1ns/10ps
`default_nettype none

module kernel_out (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire kernel_pkg::ker_out_t mem_item,
    input  wire logic                 mem_val,
    output logic                      mem_rdy,
    output kernel_pkg::ker_out_t      ker_out,
    output logic                      ker_val,
    input  wire logic                 ker_rdy
);
    import kernel_pkg::*;

    ker_out_t main_d;
    ker_out_t skid_d;
    logic     main_v;
    logic     skid_v;
    logic     in_acc;
    logic     main_free;

    assign mem_rdy   = ~skid_v; // registered, no path from ker_rdy.
    assign in_acc    = mem_val & mem_rdy;
    assign main_free = ~main_v | ker_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_v <= 1'b0;
            skid_v <= 1'b0;
        end else if (main_free) begin
            main_v <= skid_v | in_acc;
            skid_v <= 1'b0;
        end else if (in_acc) begin
            skid_v <= 1'b1; // consumer stalled, park the item.
        end
    end

    always_ff @(posedge clk) begin
        if (main_free && (skid_v || in_acc)) begin
            main_d <= skid_v ? skid_d : mem_item; // skid entry is older.
        end
        if (in_acc && !main_free) begin
            skid_d <= mem_item;
        end
    end

    assign ker_out = main_d;
    assign ker_val = main_v;

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ker_val && !ker_rdy |=> ker_val && $stable(ker_out));

endmodule

`default_nettype wire

//--- kernel_mem.sv
`timescale 1ns/10ps
`default_nettype none

module kernel_mem #(
    parameter int MEM_WORDS = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire kernel_pkg::wr_cfg_t   wr_cfg,
    input  wire kernel_pkg::rd_cfg_t   rd_cfg,
    input  wire kernel_pkg::ker_word_t wr_data,
    input  wire logic                  wr_val,
    output logic                       wr_rdy,
    output logic                       wr_done,
    output logic                       rd_active,
    output kernel_pkg::ker_out_t       mem_item,
    output logic                       mem_val,
    input  wire logic                  mem_rdy
);
    import kernel_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_BIAS,
        STREAM
    } rd_state_t;

    ker_word_t mem [MEM_WORDS];

    mem_addr_t wr_ptr;
    mem_addr_t wr_end;
    logic      wr_acc;

    rd_state_t state;
    mem_addr_t rd_start;
    mem_addr_t rd_end;
    mem_addr_t rd_ptr;
    mem_addr_t rd_addr;
    logic      rd_slot;
    logic      rd_en;
    logic      q_kern;  // mem_q holds a kernel word for the slice.
    logic      q_bias;  // mem_q holds the bias word.
    ker_word_t mem_q;
    ker_word_t bias_q;

    assign wr_acc = wr_val & wr_rdy;

    // write side.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            wr_end  <= '0;
            wr_rdy  <= 1'b0;
            wr_done <= 1'b0;
        end else if (wr_cfg.set) begin
            wr_ptr  <= '0;
            wr_end  <= wr_cfg.end_addr;
            wr_rdy  <= 1'b1;
            wr_done <= 1'b0;
        end else if (wr_acc) begin
            if (wr_ptr == wr_end) begin
                wr_rdy  <= 1'b0; // window full.
                wr_done <= 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // issue a read only when the output stage will be free.
    assign rd_slot = ~q_kern | mem_rdy;
    assign rd_en   = (state != IDLE) & rd_slot;
    assign rd_addr = (state == LOAD_BIAS) ? rd_start : rd_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            rd_start <= '0;
            rd_end   <= '0;
            rd_ptr   <= '0;
        end else if (rd_cfg.set) begin
            state    <= LOAD_BIAS; // new window replaces the old one.
            rd_start <= rd_cfg.start_addr;
            rd_end   <= rd_cfg.end_addr;
        end else if (rd_en) begin
            case (state)
                LOAD_BIAS: begin
                    state  <= STREAM;
                    rd_ptr <= rd_start + 1'b1;
                end
                STREAM: begin
                    // wrap past the bias slot.
                    rd_ptr <= (rd_ptr == rd_end) ? rd_start + 1'b1 : rd_ptr + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_kern <= 1'b0;
            q_bias <= 1'b0;
        end else begin
            q_bias <= rd_en & (state == LOAD_BIAS);
            if (rd_en) begin
                q_kern <= (state == STREAM);
            end else if (mem_rdy) begin
                q_kern <= 1'b0;
            end
        end
    end

    // one cycle read latency.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            mem_q <= mem[rd_addr];
        end
        if (q_bias) begin
            bias_q <= mem_q;
        end
    end

    assign mem_item  = '{bias: bias_q, kernel: mem_q};
    assign mem_val   = q_kern;
    assign rd_active = (state != IDLE);

    a_wr_bound: assert property (@(posedge clk) disable iff (!rst_n)
        wr_acc |-> (wr_ptr <= wr_end) && (int'(wr_ptr) < MEM_WORDS));

    // window must hold a bias and at least one kernel word.
    a_rd_window: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cfg.set |-> (rd_cfg.end_addr > rd_cfg.start_addr)
                       && (int'(rd_cfg.end_addr) < MEM_WORDS));

endmodule

`default_nettype wire

//--- ker_gearbox.sv
`timescale 1ns/10ps
`default_nettype none

module ker_gearbox (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire kernel_pkg::str_word_t str_data,
    input  wire logic                  str_val,
    output logic                       str_rdy,
    output kernel_pkg::ker_word_t      wr_data,
    output logic                       wr_val,
    input  wire logic                  wr_rdy
);
    import kernel_pkg::*;

    localparam int CNT_W = (GBOX_RATIO > 1) ? $clog2(GBOX_RATIO) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(GBOX_RATIO - 1);

    logic [CNT_W-1:0] cnt;
    logic             full;
    logic             str_acc;
    logic             wr_acc;
    ker_word_t        shreg;

    // a waiting word blocks the stream only while the memory holds off.
    assign str_rdy = ~full | wr_rdy;
    assign str_acc = str_val & str_rdy;
    assign wr_acc  = full & wr_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            full <= 1'b0;
        end else begin
            if (wr_acc) begin
                full <= 1'b0;
            end
            if (str_acc) begin
                if (cnt == CNT_LAST) begin
                    cnt  <= '0;
                    full <= 1'b1; // last beat completes the word.
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // beats enter at the top and move down, so the first ends up lowest.
    always_ff @(posedge clk) begin
        if (str_acc) begin
            shreg <= {str_data, shreg[KWORD_WIDTH-1:STR_WIDTH]};
        end
    end

    assign wr_data = shreg;
    assign wr_val  = full;

    // word must hold until the memory takes it.
    a_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wr_val && !wr_rdy |=> wr_val && $stable(wr_data));

endmodule

`default_nettype wire

//--- apb_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apb_cfg_regs (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire kernel_pkg::cfg_addr_t paddr,
    input  wire logic [31:0]           pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  wire logic                  wr_done,
    input  wire logic                  rd_active,
    output kernel_pkg::wr_cfg_t        wr_cfg,
    output kernel_pkg::rd_cfg_t        rd_cfg
);
    import kernel_pkg::*;

    localparam int RD_END_LSB = 16; // read end address sits in the upper half.

    logic      access;
    logic      hit_wr;
    logic      hit_rd;
    logic      hit_status;
    logic      cmd_wr;
    logic      cmd_rd;
    logic      wr_set;
    logic      rd_set;
    mem_addr_t wr_end;
    mem_addr_t rd_start;
    mem_addr_t rd_end;

    assign access     = psel & penable; // access phase only.
    assign hit_wr     = (paddr == CFG_KER_WR);
    assign hit_rd     = (paddr == CFG_KER_RD);
    assign hit_status = (paddr == CFG_STATUS);

    assign cmd_wr = access & pwrite & hit_wr;
    assign cmd_rd = access & pwrite & hit_rd;

    // no wait states.
    assign pready  = 1'b1;
    assign pslverr = access & (~(hit_wr | hit_rd | hit_status) | (pwrite & hit_status));

    always_comb begin
        prdata = '0;
        if (access & ~pwrite & hit_status) begin
            prdata[0] = wr_done;
            prdata[1] = rd_active;
        end
    end

    // command pulses, one cycle after the access phase.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_set <= 1'b0;
            rd_set <= 1'b0;
        end else begin
            wr_set <= cmd_wr;
            rd_set <= cmd_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            wr_end <= pwdata[0 +: MEM_AWIDTH];
        end
        if (cmd_rd) begin
            rd_start <= pwdata[0 +: MEM_AWIDTH];
            rd_end   <= pwdata[RD_END_LSB +: MEM_AWIDTH];
        end
    end

    assign wr_cfg = '{end_addr: wr_end, set: wr_set};
    assign rd_cfg = '{start_addr: rd_start, end_addr: rd_end, set: rd_set};

    // enable without select is a broken master.
    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);

endmodule

`default_nettype wire

//--- kernel_pkg.sv
`default_nettype none

package kernel_pkg;

    // stream and weight geometry.
    parameter int STR_WIDTH   = 32;
    parameter int KER_WIDTH   = 8;
    parameter int GROUP_NB    = 2;
    parameter int DEPTH_NB    = 4;
    parameter int KWORD_WIDTH = GROUP_NB * DEPTH_NB * KER_WIDTH;
    parameter int GBOX_RATIO  = KWORD_WIDTH / STR_WIDTH; // beats per kernel word.

    parameter int MEM_AWIDTH  = 4;

    typedef logic [STR_WIDTH-1:0]   str_word_t;
    typedef logic [KWORD_WIDTH-1:0] ker_word_t;
    typedef logic [MEM_AWIDTH-1:0]  mem_addr_t;
    typedef logic [7:0]             cfg_addr_t;

    // write window command, set is a single cycle pulse.
    typedef struct packed {
        mem_addr_t end_addr;
        logic      set;
    } wr_cfg_t;

    // read window command.
    typedef struct packed {
        mem_addr_t start_addr;
        mem_addr_t end_addr;
        logic      set;
    } rd_cfg_t;

    // one output item.
    typedef struct packed {
        ker_word_t bias;
        ker_word_t kernel;
    } ker_out_t;

    // APB register map.
    parameter cfg_addr_t CFG_KER_WR = 8'h00;
    parameter cfg_addr_t CFG_KER_RD = 8'h04;
    parameter cfg_addr_t CFG_STATUS = 8'h08;

endpackage

`default_nettype wire
